//--- l1_pkg.sv
/*
 * Shared types and default sizes for the L1 data cache.
 * Imported by the request interface, the arbiter and the cache controller.
 */
`default_nettype none

package l1_pkg;

    // Default geometry, passed down as module parameters from the top level
    parameter int DEF_NUM_LSUS   = 4;
    parameter int DEF_ADDR_BITS  = 8;
    parameter int DEF_DATA_BITS  = 8;
    parameter int DEF_INDEX_BITS = 4;

    // Controller states
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_CHECK,
        ST_WRITEBACK,
        ST_FILL_READ,
        ST_FILL_WRITE,
        ST_DONE
    } cache_state_e;

    // Request kind
    typedef enum logic {
        OP_READ,
        OP_WRITE
    } req_op_e;

endpackage

`default_nettype wire

//--- cache_req_if.sv
/*
 * Single granted request path from the LSU arbiter to the cache controller.
 * The arbiter presents the request, the controller pulses accept and done.
 */
`timescale 1ns/10ps
`default_nettype none

interface cache_req_if #(
    parameter int addr_bits = l1_pkg::DEF_ADDR_BITS,
    parameter int data_bits = l1_pkg::DEF_DATA_BITS
);
    import l1_pkg::*;

    logic                 req;
    req_op_e              op;
    logic [addr_bits-1:0] addr;
    logic [data_bits-1:0] wdata;

    // Completion side, driven by the controller
    logic                 accept;
    logic                 done;
    logic [data_bits-1:0] rdata;

    modport arb  (output req, op, addr, wdata, input accept, done, rdata);
    modport ctrl (input req, op, addr, wdata, output accept, done, rdata);

endinterface

`default_nettype wire

//--- lsu_arbiter.sv
/*
 * Round-robin arbiter picking one LSU request for the cache controller.
 * The grant is locked from accept to done; ready and read data go back per LSU.
 */
`timescale 1ns/10ps
`default_nettype none

module lsu_arbiter #(
    parameter int num_lsus  = l1_pkg::DEF_NUM_LSUS,
    parameter int addr_bits = l1_pkg::DEF_ADDR_BITS,
    parameter int data_bits = l1_pkg::DEF_DATA_BITS
) (
    input  wire                  clk,
    input  wire                  reset,
    input  wire  [num_lsus-1:0]  lsu_read_valid,
    input  wire  [addr_bits-1:0] lsu_read_address [num_lsus-1:0],
    input  wire  [num_lsus-1:0]  lsu_write_valid,
    input  wire  [addr_bits-1:0] lsu_write_address [num_lsus-1:0],
    input  wire  [data_bits-1:0] lsu_write_data [num_lsus-1:0],
    output logic [num_lsus-1:0]  lsu_read_ready,
    output logic [data_bits-1:0] lsu_read_data [num_lsus-1:0],
    output logic [num_lsus-1:0]  lsu_write_ready,
    cache_req_if.arb             req
);
    import l1_pkg::*;

    localparam int sel_bits = (num_lsus > 1) ? $clog2(num_lsus) : 1;

    logic [sel_bits-1:0] last_served;
    logic [sel_bits-1:0] grant_q;
    logic                locked;
    req_op_e             locked_op;

    logic [sel_bits-1:0] pick;
    logic                found;
    req_op_e             pick_op;
    logic [sel_bits-1:0] cur;

    // Search starts at the LSU after the one served last
    always_comb begin
        int cand;
        found = 1'b0;
        pick  = last_served;
        for (int i = 1; i <= num_lsus; i++) begin
            cand = (int'(last_served) + i) % num_lsus;
            if (!found && (lsu_read_valid[cand] || lsu_write_valid[cand])) begin
                found = 1'b1;
                pick  = sel_bits'(cand);
            end
        end
    end

    // Reads go first when an LSU asks for both
    always_comb begin
        if (lsu_read_valid[pick]) begin
            pick_op = OP_READ;
        end else begin
            pick_op = OP_WRITE;
        end
    end

    assign cur = locked ? grant_q : pick;

    always_comb begin
        req.req   = locked || found;
        req.op    = locked ? locked_op : pick_op;
        req.wdata = lsu_write_data[cur];
        if (req.op == OP_READ) begin
            req.addr = lsu_read_address[cur];
        end else begin
            req.addr = lsu_write_address[cur];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            last_served <= sel_bits'(num_lsus - 1);
            grant_q     <= '0;
            locked      <= 1'b0;
            locked_op   <= OP_READ;
        end else if (req.accept) begin
            last_served <= pick;
            grant_q     <= pick;
            locked      <= 1'b1;
            locked_op   <= pick_op;
        end else if (req.done) begin
            locked <= 1'b0;
        end
    end

    // Ready follows done in the same cycle
    always_comb begin
        lsu_read_ready  = '0;
        lsu_write_ready = '0;
        if (req.done) begin
            if (locked_op == OP_READ) begin
                lsu_read_ready[grant_q] = 1'b1;
            end else begin
                lsu_write_ready[grant_q] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req.done && locked_op == OP_READ) begin
            lsu_read_data[grant_q] <= req.rdata;
        end
    end

endmodule

`default_nettype wire

//--- dcache_ctrl.sv
/*
 * Direct-mapped cache controller with write-back hits and write-through misses.
 * Serves one request from the arbiter at a time and drives the memory side.
 */
`timescale 1ns/10ps
`default_nettype none

module dcache_ctrl #(
    parameter int addr_bits  = l1_pkg::DEF_ADDR_BITS,
    parameter int data_bits  = l1_pkg::DEF_DATA_BITS,
    parameter int index_bits = l1_pkg::DEF_INDEX_BITS
) (
    input  wire                  clk,
    input  wire                  reset,
    input  wire                  cache_flush,
    cache_req_if.ctrl            req,
    output logic                 mem_read_valid,
    output logic [addr_bits-1:0] mem_read_address,
    input  wire                  mem_read_ready,
    input  wire  [data_bits-1:0] mem_read_data,
    output logic                 mem_write_valid,
    output logic [addr_bits-1:0] mem_write_address,
    output logic [data_bits-1:0] mem_write_data,
    input  wire                  mem_write_ready
);
    import l1_pkg::*;

    localparam int tag_bits  = addr_bits - index_bits;
    localparam int num_lines = 1 << index_bits;

    // Line storage
    logic [data_bits-1:0] data_mem [num_lines];
    logic [tag_bits-1:0]  tag_mem  [num_lines];
    logic [num_lines-1:0] valid_bits;
    logic [num_lines-1:0] dirty_bits;

    cache_state_e state;
    cache_state_e next_state;

    // Captured request
    req_op_e              cur_op;
    logic [addr_bits-1:0] cur_addr;
    logic [data_bits-1:0] cur_wdata;
    logic [data_bits-1:0] rdata_q;

    logic [tag_bits-1:0]   addr_tag;
    logic [index_bits-1:0] addr_index;
    logic [tag_bits-1:0]   line_tag;
    logic [data_bits-1:0]  line_data;
    logic                  line_valid;
    logic                  line_dirty;
    logic                  hit;

    // Array write controls
    logic                 line_we;
    logic                 line_fill;
    logic [data_bits-1:0] line_wdata;

    assign addr_tag   = cur_addr[addr_bits-1:index_bits];
    assign addr_index = cur_addr[index_bits-1:0];
    assign line_tag   = tag_mem[addr_index];
    assign line_data  = data_mem[addr_index];
    assign line_valid = valid_bits[addr_index];
    assign line_dirty = dirty_bits[addr_index];
    assign hit        = line_valid && (line_tag == addr_tag);

    assign req.accept = (state == ST_IDLE) && req.req;
    assign req.done   = (state == ST_DONE);
    assign req.rdata  = rdata_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            ST_IDLE: begin
                if (req.req) begin
                    next_state = ST_CHECK;
                end
            end
            ST_CHECK: begin
                if (hit) begin
                    next_state = ST_DONE;
                end else if (line_valid && line_dirty) begin
                    next_state = ST_WRITEBACK;
                end else if (cur_op == OP_READ) begin
                    next_state = ST_FILL_READ;
                end else begin
                    next_state = ST_FILL_WRITE;
                end
            end
            ST_WRITEBACK: begin
                if (mem_write_ready) begin
                    next_state = (cur_op == OP_READ) ? ST_FILL_READ : ST_FILL_WRITE;
                end
            end
            ST_FILL_READ: begin
                if (mem_read_ready) begin
                    next_state = ST_DONE;
                end
            end
            ST_FILL_WRITE: begin
                if (mem_write_ready) begin
                    next_state = ST_DONE;
                end
            end
            ST_DONE: begin
                next_state = ST_IDLE;
            end
            default: begin
                next_state = ST_IDLE;
            end
        endcase
    end

    // Request is latched on the accept edge
    always_ff @(posedge clk) begin
        if (req.accept) begin
            cur_op    <= req.op;
            cur_addr  <= req.addr;
            cur_wdata <= req.wdata;
        end
    end

    // Write hits and both kinds of fill update the line
    always_comb begin
        line_we    = 1'b0;
        line_fill  = 1'b0;
        line_wdata = cur_wdata;
        case (state)
            ST_CHECK: begin
                line_we = hit && (cur_op == OP_WRITE);
            end
            ST_FILL_READ: begin
                line_we    = mem_read_ready;
                line_fill  = mem_read_ready;
                line_wdata = mem_read_data;
            end
            ST_FILL_WRITE: begin
                line_we   = mem_write_ready;
                line_fill = mem_write_ready;
            end
            default: begin
                line_we = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (line_we) begin
            data_mem[addr_index] <= line_wdata;
        end
        if (line_fill) begin
            tag_mem[addr_index] <= addr_tag;
        end
    end

    // Flush drops every line, dirty or not
    always_ff @(posedge clk) begin
        if (reset || cache_flush) begin
            valid_bits <= '0;
            dirty_bits <= '0;
        end else if (line_we) begin
            valid_bits[addr_index] <= 1'b1;
            dirty_bits[addr_index] <= !line_fill;
        end
    end

    // Read result, returned with done
    always_ff @(posedge clk) begin
        if (state == ST_CHECK && hit && cur_op == OP_READ) begin
            rdata_q <= line_data;
        end else if (state == ST_FILL_READ && mem_read_ready) begin
            rdata_q <= mem_read_data;
        end
    end

    // Memory strobes follow the state directly
    assign mem_read_valid   = (state == ST_FILL_READ);
    assign mem_read_address = cur_addr;
    assign mem_write_valid  = (state == ST_WRITEBACK) || (state == ST_FILL_WRITE);

    // Victim address rebuilt from the stored tag
    always_comb begin
        if (state == ST_WRITEBACK) begin
            mem_write_address = {line_tag, addr_index};
            mem_write_data    = line_data;
        end else begin
            mem_write_address = cur_addr;
            mem_write_data    = cur_wdata;
        end
    end

endmodule

`default_nettype wire

//--- l1_dcache.sv
/*
 * L1 data cache top level with per-LSU ports and one data memory port.
 * Connects the round-robin arbiter to the cache controller.
 */
`timescale 1ns/10ps
`default_nettype none

module l1_dcache #(
    parameter int num_lsus   = l1_pkg::DEF_NUM_LSUS,
    parameter int addr_bits  = l1_pkg::DEF_ADDR_BITS,
    parameter int data_bits  = l1_pkg::DEF_DATA_BITS,
    parameter int index_bits = l1_pkg::DEF_INDEX_BITS
) (
    input  wire                  clk,
    input  wire                  reset,
    input  wire                  cache_flush,
    // LSU side
    input  wire  [num_lsus-1:0]  lsu_read_valid,
    input  wire  [addr_bits-1:0] lsu_read_address [num_lsus-1:0],
    output logic [num_lsus-1:0]  lsu_read_ready,
    output logic [data_bits-1:0] lsu_read_data [num_lsus-1:0],
    input  wire  [num_lsus-1:0]  lsu_write_valid,
    input  wire  [addr_bits-1:0] lsu_write_address [num_lsus-1:0],
    input  wire  [data_bits-1:0] lsu_write_data [num_lsus-1:0],
    output logic [num_lsus-1:0]  lsu_write_ready,
    // Data memory side
    output logic                 mem_read_valid,
    output logic [addr_bits-1:0] mem_read_address,
    input  wire                  mem_read_ready,
    input  wire  [data_bits-1:0] mem_read_data,
    output logic                 mem_write_valid,
    output logic [addr_bits-1:0] mem_write_address,
    output logic [data_bits-1:0] mem_write_data,
    input  wire                  mem_write_ready
);

    cache_req_if #(
        .addr_bits(addr_bits),
        .data_bits(data_bits)
    ) req_bus ();

    lsu_arbiter #(
        .num_lsus (num_lsus),
        .addr_bits(addr_bits),
        .data_bits(data_bits)
    ) u_arbiter (
        .clk              (clk),
        .reset            (reset),
        .lsu_read_valid   (lsu_read_valid),
        .lsu_read_address (lsu_read_address),
        .lsu_write_valid  (lsu_write_valid),
        .lsu_write_address(lsu_write_address),
        .lsu_write_data   (lsu_write_data),
        .lsu_read_ready   (lsu_read_ready),
        .lsu_read_data    (lsu_read_data),
        .lsu_write_ready  (lsu_write_ready),
        .req              (req_bus.arb)
    );

    dcache_ctrl #(
        .addr_bits (addr_bits),
        .data_bits (data_bits),
        .index_bits(index_bits)
    ) u_ctrl (
        .clk              (clk),
        .reset            (reset),
        .cache_flush      (cache_flush),
        .req              (req_bus.ctrl),
        .mem_read_valid   (mem_read_valid),
        .mem_read_address (mem_read_address),
        .mem_read_ready   (mem_read_ready),
        .mem_read_data    (mem_read_data),
        .mem_write_valid  (mem_write_valid),
        .mem_write_address(mem_write_address),
        .mem_write_data   (mem_write_data),
        .mem_write_ready  (mem_write_ready)
    );

endmodule

`default_nettype wire

//--- tb_l1_dcache_assert.sv
/*
 * Concurrent checks on the cache's top-level ports, bound into l1_dcache.
 */
`timescale 1ns/10ps
`default_nettype none

module tb_l1_dcache_assert #(
    parameter int num_lsus  = l1_pkg::DEF_NUM_LSUS,
    parameter int addr_bits = l1_pkg::DEF_ADDR_BITS,
    parameter int data_bits = l1_pkg::DEF_DATA_BITS
) (
    input wire                 clk,
    input wire                 reset,
    input wire [num_lsus-1:0]  lsu_read_ready,
    input wire [num_lsus-1:0]  lsu_write_ready,
    input wire                 mem_read_valid,
    input wire [addr_bits-1:0] mem_read_address,
    input wire                 mem_read_ready,
    input wire                 mem_write_valid,
    input wire [addr_bits-1:0] mem_write_address,
    input wire [data_bits-1:0] mem_write_data,
    input wire                 mem_write_ready
);
    int fail_count = 0;

    assert property (@(posedge clk) disable iff (reset) !(mem_read_valid && mem_write_valid))
    else begin
        fail_count++;
        $error("Memory read and write valid high together");
    end

    assert property (@(posedge clk) disable iff (reset) $onehot0({lsu_read_ready, lsu_write_ready}))
    else begin
        fail_count++;
        $error("More than one LSU ready high");
    end

    // Address held while a read waits
    assert property (@(posedge clk) disable iff (reset)
        mem_read_valid && !mem_read_ready |=> mem_read_valid && $stable(mem_read_address))
    else begin
        fail_count++;
        $error("Memory read request changed before ready");
    end

    assert property (@(posedge clk) disable iff (reset)
        mem_write_valid && !mem_write_ready |=>
            mem_write_valid && $stable(mem_write_address) && $stable(mem_write_data))
    else begin
        fail_count++;
        $error("Memory write request changed before ready");
    end

    assert property (@(posedge clk) disable iff (reset)
        |{lsu_read_ready, lsu_write_ready} |=> !(|{lsu_read_ready, lsu_write_ready}))
    else begin
        fail_count++;
        $error("LSU ready lasted more than one cycle");
    end

endmodule

bind l1_dcache tb_l1_dcache_assert #(
    .num_lsus (num_lsus),
    .addr_bits(addr_bits),
    .data_bits(data_bits)
) u_assert (
    .clk              (clk),
    .reset            (reset),
    .lsu_read_ready   (lsu_read_ready),
    .lsu_write_ready  (lsu_write_ready),
    .mem_read_valid   (mem_read_valid),
    .mem_read_address (mem_read_address),
    .mem_read_ready   (mem_read_ready),
    .mem_write_valid  (mem_write_valid),
    .mem_write_address(mem_write_address),
    .mem_write_data   (mem_write_data),
    .mem_write_ready  (mem_write_ready)
);

`default_nettype wire

//--- tb_l1_dcache.sv
/*
 * Testbench for the L1 data cache, playing four LSUs and the data memory.
 * Directed cases run first, then random traffic checked against a reference model.
 */
`timescale 1ns/10ps
`default_nettype none

module tb_l1_dcache;
    import l1_pkg::*;

    localparam int num_lsus    = DEF_NUM_LSUS;
    localparam int addr_bits   = DEF_ADDR_BITS;
    localparam int data_bits   = DEF_DATA_BITS;
    localparam int index_bits  = DEF_INDEX_BITS;
    localparam int tag_bits    = addr_bits - index_bits;
    localparam int num_lines   = 1 << index_bits;
    localparam int mem_words   = 1 << addr_bits;
    localparam int drive_delay = 10;
    localparam int max_wait    = 100;

    logic                 clk;
    logic                 reset;
    logic                 cache_flush;
    logic [num_lsus-1:0]  lsu_read_valid;
    logic [addr_bits-1:0] lsu_read_address [num_lsus-1:0];
    logic [num_lsus-1:0]  lsu_read_ready;
    logic [data_bits-1:0] lsu_read_data [num_lsus-1:0];
    logic [num_lsus-1:0]  lsu_write_valid;
    logic [addr_bits-1:0] lsu_write_address [num_lsus-1:0];
    logic [data_bits-1:0] lsu_write_data [num_lsus-1:0];
    logic [num_lsus-1:0]  lsu_write_ready;
    logic                 mem_read_valid;
    logic [addr_bits-1:0] mem_read_address;
    logic                 mem_read_ready;
    logic [data_bits-1:0] mem_read_data;
    logic                 mem_write_valid;
    logic [addr_bits-1:0] mem_write_address;
    logic [data_bits-1:0] mem_write_data;
    logic                 mem_write_ready;

    // Memory played by the testbench, and the model's view of it
    logic [data_bits-1:0] mem_array [mem_words];
    logic [data_bits-1:0] model_mem [mem_words];
    // Shadow of the cache lines
    logic [tag_bits-1:0]  sh_tag  [num_lines];
    logic [data_bits-1:0] sh_data [num_lines];
    logic [num_lines-1:0] sh_valid;
    logic [num_lines-1:0] sh_dirty;
    // Memory traffic seen since the last completion
    logic [addr_bits-1:0] wr_addr_q [$];
    logic [data_bits-1:0] wr_data_q [$];
    logic [addr_bits-1:0] rd_addr_q [$];

    int seed;
    int errors;
    int checks;
    int last_served;
    int served_order [$];

    l1_dcache #(
        .num_lsus  (num_lsus),
        .addr_bits (addr_bits),
        .data_bits (data_bits),
        .index_bits(index_bits)
    ) DUT (
        .clk              (clk),
        .reset            (reset),
        .cache_flush      (cache_flush),
        .lsu_read_valid   (lsu_read_valid),
        .lsu_read_address (lsu_read_address),
        .lsu_read_ready   (lsu_read_ready),
        .lsu_read_data    (lsu_read_data),
        .lsu_write_valid  (lsu_write_valid),
        .lsu_write_address(lsu_write_address),
        .lsu_write_data   (lsu_write_data),
        .lsu_write_ready  (lsu_write_ready),
        .mem_read_valid   (mem_read_valid),
        .mem_read_address (mem_read_address),
        .mem_read_ready   (mem_read_ready),
        .mem_read_data    (mem_read_data),
        .mem_write_valid  (mem_write_valid),
        .mem_write_address(mem_write_address),
        .mem_write_data   (mem_write_data),
        .mem_write_ready  (mem_write_ready)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("Error at %0t: %s = %0h, expected %0h", $time, name, got, exp);
        end
    endtask

    // Reference model, applied when a request completes
    task automatic complete_request(input int id, input req_op_e op,
                                    input logic [addr_bits-1:0] addr,
                                    input logic [data_bits-1:0] wdata);
        logic [index_bits-1:0] idx;
        logic [tag_bits-1:0]   tag;
        logic [addr_bits-1:0]  exp_addr [$];
        logic [data_bits-1:0]  exp_data [$];
        int                    exp_reads;
        idx = addr[index_bits-1:0];
        tag = addr[addr_bits-1:index_bits];
        exp_reads = 0;
        if (sh_valid[idx] && sh_tag[idx] == tag) begin
            if (op == OP_WRITE) begin
                sh_data[idx]  = wdata;
                sh_dirty[idx] = 1'b1;
            end else begin
                check_value($sformatf("lsu_read_data[%0d]", id), lsu_read_data[id],
                            sh_data[idx]);
            end
        end else begin
            // Dirty victim goes back to its old address first
            if (sh_valid[idx] && sh_dirty[idx]) begin
                exp_addr.push_back({sh_tag[idx], idx});
                exp_data.push_back(sh_data[idx]);
                model_mem[{sh_tag[idx], idx}] = sh_data[idx];
            end
            if (op == OP_READ) begin
                exp_reads = 1;
                sh_data[idx] = model_mem[addr];
                check_value($sformatf("lsu_read_data[%0d]", id), lsu_read_data[id],
                            model_mem[addr]);
            end else begin
                exp_addr.push_back(addr);
                exp_data.push_back(wdata);
                model_mem[addr] = wdata;
                sh_data[idx] = wdata;
            end
            sh_tag[idx]   = tag;
            sh_valid[idx] = 1'b1;
            sh_dirty[idx] = 1'b0;
        end
        check_value("mem_write_valid handshakes", wr_addr_q.size(), exp_addr.size());
        for (int k = 0; k < exp_addr.size() && k < wr_addr_q.size(); k++) begin
            check_value("mem_write_address", wr_addr_q[k], exp_addr[k]);
            check_value("mem_write_data", wr_data_q[k], exp_data[k]);
        end
        check_value("mem_read_valid handshakes", rd_addr_q.size(), exp_reads);
        if (exp_reads == 1 && rd_addr_q.size() == 1) begin
            check_value("mem_read_address", rd_addr_q[0], addr);
        end
        wr_addr_q.delete();
        wr_data_q.delete();
        rd_addr_q.delete();
        served_order.push_back(id);
        last_served = id;
    endtask

    // Called a drive delay after a rising edge, returns at the same phase
    task automatic issue_request(input int id, input req_op_e op,
                                 input logic [addr_bits-1:0] addr,
                                 input logic [data_bits-1:0] wdata,
                                 output int edges, output logic mem_seen);
        logic got;
        logic rd_seen;
        edges = 0;
        mem_seen = 1'b0;
        got = 1'b0;
        rd_seen = 1'b0;
        if (op == OP_READ) begin
            lsu_read_address[id] = addr;
            lsu_read_valid[id] = 1'b1;
        end else begin
            lsu_write_address[id] = addr;
            lsu_write_data[id] = wdata;
            lsu_write_valid[id] = 1'b1;
        end
        while (!got && edges < max_wait) begin
            @(posedge clk);
            edges++;
            got = lsu_read_ready[id] || lsu_write_ready[id];
            rd_seen = lsu_read_ready[id];
            if (mem_read_valid || mem_write_valid) begin
                mem_seen = 1'b1;
            end
        end
        #drive_delay;
        lsu_read_valid[id] = 1'b0;
        lsu_write_valid[id] = 1'b0;
        if (!got) begin
            errors++;
            $display("Error at %0t: LSU %0d got no ready within %0d cycles", $time, id, max_wait);
        end else begin
            check_value($sformatf("lsu_read_ready[%0d]", id), rd_seen, op == OP_READ);
            complete_request(id, op, addr, wdata);
        end
    endtask

    task automatic expect_hit(input int id, input req_op_e op,
                              input logic [addr_bits-1:0] addr,
                              input logic [data_bits-1:0] wdata);
        int   edges;
        logic seen;
        checks++;
        assert (sh_valid[addr[index_bits-1:0]] &&
                sh_tag[addr[index_bits-1:0]] == addr[addr_bits-1:index_bits]) else begin
            errors++;
            $display("Error at %0t: address %0h is not cached in the model", $time, addr);
        end
        issue_request(id, op, addr, wdata, edges, seen);
        // Ready is sampled two edges after the accept edge
        check_value("hit ready edge count", edges, 3);
        check_value("memory valid during hit", seen, 1'b0);
    endtask

    task automatic flush_cache();
        cache_flush = 1'b1;
        @(posedge clk);
        #drive_delay;
        cache_flush = 1'b0;
        sh_valid = '0;
        sh_dirty = '0;
    endtask

    // All LSUs request at once, and the first one served asks again at once
    task automatic check_round_robin();
        int   first;
        int   start;
        int   again;
        int   edges [num_lsus];
        logic seen [num_lsus];
        first = served_order.size();
        start = last_served;
        again = (start + 1) % num_lsus;
        fork
            begin
                issue_request(0, OP_READ, 8'h03, 8'h00, edges[0], seen[0]);
                if (again == 0) begin
                    issue_request(0, OP_READ, 8'h17, 8'h00, edges[0], seen[0]);
                end
            end
            begin
                issue_request(1, OP_WRITE, 8'h17, 8'h5e, edges[1], seen[1]);
                if (again == 1) begin
                    issue_request(1, OP_READ, 8'h2b, 8'h00, edges[1], seen[1]);
                end
            end
            begin
                issue_request(2, OP_READ, 8'h2b, 8'h00, edges[2], seen[2]);
                if (again == 2) begin
                    issue_request(2, OP_WRITE, 8'h5b, 8'h91, edges[2], seen[2]);
                end
            end
            begin
                issue_request(3, OP_WRITE, 8'h03, 8'hc4, edges[3], seen[3]);
                if (again == 3) begin
                    issue_request(3, OP_READ, 8'h43, 8'h00, edges[3], seen[3]);
                end
            end
        join
        check_value("grant count", served_order.size() - first, num_lsus + 1);
        for (int k = 0; k <= num_lsus && first + k < served_order.size(); k++) begin
            check_value("granted LSU", served_order[first + k], (start + 1 + k) % num_lsus);
        end
    endtask

    task automatic run_lsu(input int id, input int count);
        int                   edges;
        logic                 seen;
        int                   idle;
        int                   r;
        req_op_e              op;
        logic [addr_bits-1:0] addr;
        for (int n = 0; n < count; n++) begin
            idle = ($random(seed) & 32'h7fff_ffff) % 4;
            repeat (idle) begin
                @(posedge clk);
                #drive_delay;
            end
            r = $random(seed) & 15;
            // Four tags over four indexes keep conflicts frequent
            addr = addr_bits'((((r >> 2) & 3) << index_bits) | (r & 3));
            op = req_op_e'($random(seed) & 1);
            issue_request(id, op, addr, data_bits'($random(seed)), edges, seen);
        end
    endtask

    // Answers each memory valid after 1 to 4 cycles
    initial begin : memory_responder
        int delay;
        forever begin
            @(posedge clk);
            if (!reset && (mem_read_valid || mem_write_valid)) begin
                delay = 1 + (($random(seed) & 32'h7fff_ffff) % 4);
                repeat (delay - 1) @(posedge clk);
                #drive_delay;
                if (mem_read_valid) begin
                    mem_read_data = mem_array[mem_read_address];
                    rd_addr_q.push_back(mem_read_address);
                    mem_read_ready = 1'b1;
                end else begin
                    mem_array[mem_write_address] = mem_write_data;
                    wr_addr_q.push_back(mem_write_address);
                    wr_data_q.push_back(mem_write_data);
                    mem_write_ready = 1'b1;
                end
                @(posedge clk);
                #drive_delay;
                mem_read_ready = 1'b0;
                mem_write_ready = 1'b0;
            end
        end
    end

    initial begin : main
        int   edges;
        logic seen;
        seed = 52;
        errors = 0;
        checks = 0;
        last_served = num_lsus - 1;
        for (int a = 0; a < mem_words; a++) begin
            mem_array[a] = data_bits'(a * 13 + 7);
            model_mem[a] = data_bits'(a * 13 + 7);
        end
        sh_valid = '0;
        sh_dirty = '0;
        reset = 1'b1;
        cache_flush = 1'b0;
        lsu_read_valid = '0;
        lsu_write_valid = '0;
        for (int i = 0; i < num_lsus; i++) begin
            lsu_read_address[i] = '0;
            lsu_write_address[i] = '0;
            lsu_write_data[i] = '0;
        end
        mem_read_ready = 1'b0;
        mem_read_data = '0;
        mem_write_ready = 1'b0;
        repeat (3) @(posedge clk);
        #drive_delay;
        reset = 1'b0;

        // Miss fills the line, then hits on it
        issue_request(0, OP_READ, 8'h12, 8'h00, edges, seen);
        expect_hit(0, OP_READ, 8'h12, 8'h00);
        expect_hit(0, OP_WRITE, 8'h12, 8'ha5);
        // Same index, other tag: writeback then fetch
        issue_request(1, OP_READ, 8'h32, 8'h00, edges, seen);
        // Write miss goes through and leaves the line clean
        issue_request(2, OP_WRITE, 8'h45, 8'h3c, edges, seen);
        issue_request(2, OP_READ, 8'h65, 8'h00, edges, seen);
        // Dirty data dropped by the flush
        expect_hit(3, OP_WRITE, 8'h65, 8'h77);
        flush_cache();
        issue_request(3, OP_READ, 8'h65, 8'h00, edges, seen);
        check_round_robin();
        check_round_robin();
        fork
            run_lsu(0, 40);
            run_lsu(1, 40);
            run_lsu(2, 40);
            run_lsu(3, 40);
        join

        errors += DUT.u_assert.fail_count;
        $display("Checks: %0d, errors: %0d (assertion failures: %0d)",
                 checks, errors, DUT.u_assert.fail_count);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
l1_pkg.sv
cache_req_if.sv
lsu_arbiter.sv
dcache_ctrl.sv
l1_dcache.sv
tb_l1_dcache_assert.sv
tb_l1_dcache.sv

//--- Bender.yml
package:
  name: l1_dcache

sources:
  - l1_pkg.sv
  - cache_req_if.sv
  - lsu_arbiter.sv
  - dcache_ctrl.sv
  - l1_dcache.sv
  - target: simulation
    files:
      - tb_l1_dcache_assert.sv
      - tb_l1_dcache.sv
